//--- src/noc_pkg.sv
`default_nettype none

package noc_pkg;

    // ******************************************************************
    // mesh and flit dimensions
    // ******************************************************************
    localparam int DATA_WIDTH  = 16;  // flit payload.
    localparam int COORD_WIDTH = 3;   // one mesh coordinate.
    localparam int NUM_PORTS   = 5;   // router directions.

    typedef enum logic [1:0] {
        HEAD,
        BODY,
        TAIL,
        HEAD_TAIL
    } flit_type_t;

    // order fixes the bit of each direction in on/off and valid vectors.
    typedef enum logic [2:0] {
        LOCAL,
        NORTH,
        SOUTH,
        EAST,
        WEST
    } port_t;

    // ******************************************************************
    // payload views
    // ******************************************************************
    typedef struct packed {
        logic [COORD_WIDTH-1:0]              dest_x;
        logic [COORD_WIDTH-1:0]              dest_y;
        logic [DATA_WIDTH-2*COORD_WIDTH-1:0] pkt_id;  // rest of the word.
    } head_fields_t;

    // head flits carry routing fields, all others carry raw data.
    typedef union packed {
        head_fields_t          head;
        logic [DATA_WIDTH-1:0] data;
    } flit_payload_u;

    typedef struct packed {
        flit_type_t    flit_type;
        flit_payload_u payload;
    } flit_novc_t;

    typedef struct packed {
        flit_novc_t flit;
        port_t      out_port;  // direction picked by the route stage.
    } routed_flit_t;

endpackage

`default_nettype wire

//--- src/circular_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module circular_buffer #(
    parameter int BUFFER_SIZE    = 8,
    parameter int PIPELINE_DEPTH = 5
)(
    input  wire                      clk,
    input  wire                      rst,
    input  wire noc_pkg::flit_novc_t data_i,
    input  wire                      read_i,
    input  wire                      write_i,
    output noc_pkg::flit_novc_t      data_o,
    output logic                     is_full_o,
    output logic                     is_empty_o,
    output logic                     on_off_o
);

    localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    localparam logic [CNT_W-1:0] FULL_LEVEL = CNT_W'(BUFFER_SIZE);
    localparam logic [CNT_W-1:0] ON_LEVEL   = CNT_W'(PIPELINE_DEPTH);
    localparam logic [CNT_W-1:0] OFF_LEVEL  = CNT_W'(BUFFER_SIZE - PIPELINE_DEPTH);

    noc_pkg::flit_novc_t mem_q [BUFFER_SIZE];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_next;

    logic do_read;
    logic do_write;
    logic on_off_next;

    // wrap at BUFFER_SIZE, which need not be a power of two.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(BUFFER_SIZE - 1))
            return '0;
        else
            return ptr + 1'b1;
    endfunction

    // ******************************************************************
    // operation decode
    // ******************************************************************
    always_comb
    begin
        do_read  = read_i & ~is_empty_o;               // empty read ignored.
        do_write = write_i & (~is_full_o | do_read);   // full write dropped.

        case ({do_write, do_read})
            2'b10:   count_next = count_q + 1'b1;
            2'b01:   count_next = count_q - 1'b1;
            default: count_next = count_q;
        endcase

        // hysteresis on the fill level.
        if ((count_next < count_q) && (count_next < ON_LEVEL))
            on_off_next = 1'b1;
        else if ((count_next > count_q) && (count_next > OFF_LEVEL))
            on_off_next = 1'b0;
        else
            on_off_next = on_off_o;
    end

    // ******************************************************************
    // state
    // ******************************************************************
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rd_ptr_q   <= '0;
            wr_ptr_q   <= '0;
            count_q    <= '0;
            is_full_o  <= 1'b0;
            is_empty_o <= 1'b1;
            on_off_o   <= 1'b1;  // upstream may send after reset.
        end
        else
        begin
            if (do_read)
                rd_ptr_q <= next_ptr(rd_ptr_q);
            if (do_write)
                wr_ptr_q <= next_ptr(wr_ptr_q);
            count_q    <= count_next;
            is_full_o  <= (count_next == FULL_LEVEL);
            is_empty_o <= (count_next == '0);
            on_off_o   <= on_off_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_write)
            mem_q[wr_ptr_q] <= data_i;
    end

    assign data_o = mem_q[rd_ptr_q];  // head of queue, no read latency.

    // upstream has to honour on/off well before the ring fills.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (write_i && is_full_o) |-> read_i);

    // pointers meet only when the ring is empty or full.
    a_flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(is_full_o && is_empty_o) &&
        ((rd_ptr_q == wr_ptr_q) == (is_full_o || is_empty_o)));

endmodule

`default_nettype wire

//--- src/route_compute.sv
`timescale 1ns/100ps
`default_nettype none

module route_compute #(
    parameter int LOCAL_X = 2,
    parameter int LOCAL_Y = 2
)(
    input  wire                      clk,
    input  wire                      rst,
    input  wire noc_pkg::flit_novc_t data_i,
    input  wire                      is_empty_i,
    input  wire                      stall_i,
    output logic                     read_o,
    output noc_pkg::routed_flit_t    routed_o,
    output logic                     valid_o
);

    localparam int CW = noc_pkg::COORD_WIDTH;

    localparam logic [CW-1:0] X_HERE = CW'(LOCAL_X);
    localparam logic [CW-1:0] Y_HERE = CW'(LOCAL_Y);

    logic            capture;
    logic            is_head;
    logic            is_last;
    noc_pkg::port_t  route_sel;

    logic            pkt_open_q;  // a head has passed, its tail not yet.
    noc_pkg::port_t  pkt_port_q;  // direction shared by the open packet.

    // dimension order, x first then y.
    function automatic noc_pkg::port_t xy_route(input noc_pkg::head_fields_t hdr);
        if (hdr.dest_x > X_HERE)
            return noc_pkg::EAST;
        else if (hdr.dest_x < X_HERE)
            return noc_pkg::WEST;
        else if (hdr.dest_y > Y_HERE)
            return noc_pkg::NORTH;
        else if (hdr.dest_y < Y_HERE)
            return noc_pkg::SOUTH;
        else
            return noc_pkg::LOCAL;
    endfunction

    always_comb
    begin
        read_o  = ~valid_o | ~stall_i;  // stage free or leaving now.
        capture = read_o & ~is_empty_i;

        is_head = (data_i.flit_type == noc_pkg::HEAD) ||
                  (data_i.flit_type == noc_pkg::HEAD_TAIL);
        is_last = (data_i.flit_type == noc_pkg::TAIL) ||
                  (data_i.flit_type == noc_pkg::HEAD_TAIL);

        // body and tail follow their head.
        route_sel = is_head ? xy_route(data_i.payload.head) : pkt_port_q;
    end

    // ******************************************************************
    // stage control and packet route
    // ******************************************************************
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            valid_o    <= 1'b0;
            pkt_open_q <= 1'b0;
            pkt_port_q <= noc_pkg::LOCAL;
        end
        else if (capture)
        begin
            valid_o    <= 1'b1;
            pkt_open_q <= ~is_last;
            if (is_head)
                pkt_port_q <= route_sel;
        end
        else if (!stall_i)
        begin
            valid_o <= 1'b0;  // flit handed to the switch stage.
        end
    end

    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            routed_o.flit     <= data_i;
            routed_o.out_port <= route_sel;
        end
    end

    // a body or tail needs a head in front of it.
    a_packet_open: assert property (@(posedge clk) disable iff (rst)
        (capture && (data_i.flit_type inside {noc_pkg::BODY, noc_pkg::TAIL}))
        |-> pkt_open_q);

endmodule

`default_nettype wire

//--- src/switch_traversal.sv
`timescale 1ns/100ps
`default_nettype none

module switch_traversal (
    input  wire                                clk,
    input  wire                                rst,
    input  wire noc_pkg::routed_flit_t         routed_i,
    input  wire                                valid_i,
    input  wire [noc_pkg::NUM_PORTS-1:0]       on_off_i,
    output logic                               stall_o,
    output noc_pkg::flit_novc_t                flit_o,
    output logic [noc_pkg::NUM_PORTS-1:0]      valid_o
);

    localparam int NP = noc_pkg::NUM_PORTS;

    noc_pkg::routed_flit_t hold_q;       // flit waiting for its output.
    logic                  hold_valid_q;

    noc_pkg::routed_flit_t cand;
    logic                  cand_valid;
    logic                  send;
    logic                  accept;
    logic [NP-1:0]         port_sel;

    // ******************************************************************
    // output selection
    // ******************************************************************
    always_comb
    begin
        // a held flit goes before anything new.
        cand       = hold_valid_q ? hold_q : routed_i;
        cand_valid = hold_valid_q | valid_i;
        port_sel   = NP'(1) << cand.out_port;
        send       = cand_valid & on_off_i[cand.out_port];

        stall_o = hold_valid_q & ~send;  // held flit still blocked.
        accept  = valid_i & ~stall_o;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hold_valid_q <= 1'b0;
            valid_o      <= '0;
        end
        else
        begin
            valid_o <= send ? port_sel : '0;
            if (hold_valid_q)
                hold_valid_q <= ~send | accept;  // refilled when it leaves.
            else
                hold_valid_q <= valid_i & ~send;
        end
    end

    always_ff @(posedge clk)
    begin
        flit_o <= cand.flit;
        // refill behind a leaving flit, or park one that is blocked.
        if (accept && (hold_valid_q ? send : !send))
            hold_q <= routed_i;
    end

    // one direction per flit, and a blocked flit keeps its place.
    a_valid_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(valid_o) && (!$past(stall_o) || (hold_valid_q && $stable(hold_q))));

endmodule

`default_nettype wire

//--- src/router_input_port.sv
`timescale 1ns/100ps
`default_nettype none

module router_input_port #(
    parameter int BUFFER_SIZE    = 8,
    parameter int PIPELINE_DEPTH = 5,
    parameter int LOCAL_X        = 2,
    parameter int LOCAL_Y        = 2
)(
    input  wire                           clk,
    input  wire                           rst,
    input  wire noc_pkg::flit_novc_t      flit_i,
    input  wire                           write_i,
    output logic                          on_off_o,
    input  wire [noc_pkg::NUM_PORTS-1:0]  on_off_i,
    output noc_pkg::flit_novc_t           flit_o,
    output logic [noc_pkg::NUM_PORTS-1:0] valid_o
);

    // ******************************************************************
    // stage links
    // ******************************************************************
    noc_pkg::flit_novc_t   buf_data;
    logic                  buf_empty;
    logic                  buf_read;
    noc_pkg::routed_flit_t routed;
    logic                  route_valid;
    logic                  sw_stall;

    circular_buffer #(
        .BUFFER_SIZE    (BUFFER_SIZE),
        .PIPELINE_DEPTH (PIPELINE_DEPTH)
    ) u_buffer (
        .clk        (clk),
        .rst        (rst),
        .data_i     (flit_i),
        .read_i     (buf_read),
        .write_i    (write_i),
        .data_o     (buf_data),
        .is_full_o  (),           // upstream is throttled by on_off_o.
        .is_empty_o (buf_empty),
        .on_off_o   (on_off_o)
    );

    route_compute #(
        .LOCAL_X (LOCAL_X),
        .LOCAL_Y (LOCAL_Y)
    ) u_route (
        .clk        (clk),
        .rst        (rst),
        .data_i     (buf_data),
        .is_empty_i (buf_empty),
        .stall_i    (sw_stall),
        .read_o     (buf_read),
        .routed_o   (routed),
        .valid_o    (route_valid)
    );

    switch_traversal u_switch (
        .clk      (clk),
        .rst      (rst),
        .routed_i (routed),
        .valid_i  (route_valid),
        .on_off_i (on_off_i),
        .stall_o  (sw_stall),
        .flit_o   (flit_o),
        .valid_o  (valid_o)
    );

endmodule

`default_nettype wire

//--- testbench/tb_router_input_port.sv
`timescale 1ns/100ps
`default_nettype none

module tb_router_input_port;

    localparam int          NP             = noc_pkg::NUM_PORTS;
    localparam int          HERE_X         = 2;    // default mesh position of the dut.
    localparam int          HERE_Y         = 2;
    localparam int          DRIVE_DELAY    = 2;    // ns after the rising edge.
    localparam int          WAIT_LIMIT     = 200;  // cycles.
    localparam int          DRAIN_LIMIT    = 600;  // cycles.
    localparam int          BP_FLITS       = 7;    // leaves five in the buffer.
    localparam int          RANDOM_PACKETS = 60;
    localparam logic [31:0] SEED           = 32'hb8722d4a;

    typedef struct packed {
        noc_pkg::flit_novc_t flit;
        logic [NP-1:0]       dir;  // one-hot output expected.
    } expect_t;

    logic                clk;
    logic                rst;
    noc_pkg::flit_novc_t flit_i;
    logic                write_i;
    logic                on_off_o;
    logic [NP-1:0]       on_off_i;
    noc_pkg::flit_novc_t flit_o;
    logic [NP-1:0]       valid_o;

    expect_t exp_q [$];  // scoreboard, oldest first.
    expect_t seen;
    string   test_name = "setup";
    int      flits_out = 0;

    router_input_port u_dut (
        .clk      (clk),
        .rst      (rst),
        .flit_i   (flit_i),
        .write_i  (write_i),
        .on_off_o (on_off_o),
        .on_off_i (on_off_i),
        .flit_o   (flit_o),
        .valid_o  (valid_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // **********************************************************************
    // error reporting and helpers
    // **********************************************************************
    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("test failed");
        $display("Fail %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_problem(input string what);
        $display("test failed");
        $display("%s: %s", test_name, what);
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual)
        else report_mismatch(what, expected, actual);
    endtask

    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // x first, then y, as seen from (HERE_X, HERE_Y).
    function automatic logic [NP-1:0] xy_onehot(input int dx, input int dy);
        noc_pkg::port_t dir;
        if (dx > HERE_X)
            dir = noc_pkg::EAST;
        else if (dx < HERE_X)
            dir = noc_pkg::WEST;
        else if (dy > HERE_Y)
            dir = noc_pkg::NORTH;
        else if (dy < HERE_Y)
            dir = noc_pkg::SOUTH;
        else
            dir = noc_pkg::LOCAL;
        return NP'(1) << dir;
    endfunction

    function automatic logic [15:0] head_word(input int dx, input int dy, input int id);
        noc_pkg::flit_payload_u p;
        p.head.dest_x = 3'(dx);
        p.head.dest_y = 3'(dy);
        p.head.pkt_id = 10'(id);
        return p.data;
    endfunction

    task automatic shuffle_outputs();
        on_off_i = NP'($urandom | $urandom);  // each direction on about 3/4 of the time.
    endtask

    task automatic wait_upstream_on();
        int waited;
        waited = 0;
        while (!on_off_o && waited < WAIT_LIMIT)
        begin
            tick();
            shuffle_outputs();
            waited++;
        end
        assert (on_off_o)
        else report_problem("timeout while waiting for on_off_o to rise");
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
        begin
            tick();
            waited++;
        end
        assert (exp_q.size() == 0)
        else report_problem($sformatf("timeout, %0d flits never left the port", exp_q.size()));
        repeat (3) tick();  // room for a stray extra pulse.
    endtask

    task automatic send_flit(input noc_pkg::flit_type_t kind, input logic [15:0] word,
                             input logic [NP-1:0] dir);
        expect_t item;
        item.flit.flit_type    = kind;
        item.flit.payload.data = word;
        item.dir               = dir;
        exp_q.push_back(item);
        flit_i   = item.flit;
        write_i  = 1'b1;
        tick();
        write_i  = 1'b0;
    endtask

    // paced sending honours on_off_o and keeps the downstream levels moving.
    task automatic send_packet(input int dx, input int dy, input int len, input bit paced,
                               input int gap);
        logic [NP-1:0]       dir;
        noc_pkg::flit_type_t kind;
        logic [15:0]         word;
        dir = xy_onehot(dx, dy);
        for (int i = 0; i < len; i++)
        begin
            if (i == 0)
            begin
                kind = (len == 1) ? noc_pkg::HEAD_TAIL : noc_pkg::HEAD;
                word = head_word(dx, dy, $urandom);
            end
            else
            begin
                kind = (i == len - 1) ? noc_pkg::TAIL : noc_pkg::BODY;
                word = 16'($urandom);
            end
            if (paced)
                wait_upstream_on();
            send_flit(kind, word, dir);
            if (paced)
            begin
                shuffle_outputs();
                if ($urandom_range(3) == 0)
                begin
                    tick();  // idle cycle on the link.
                    shuffle_outputs();
                end
            end
            repeat (gap) tick();
        end
    endtask

    // **********************************************************************
    // output monitor
    // **********************************************************************
    always @(negedge clk)
    begin
        if (!rst && valid_o != '0)
        begin
            assert (exp_q.size() != 0)
            else report_problem("a flit left the port while none was expected");
            if (exp_q.size() != 0)
            begin
                seen = exp_q.pop_front();
                assert (valid_o == seen.dir)
                else report_mismatch("direction", 32'(seen.dir), 32'(valid_o));
                assert (flit_o == seen.flit)
                else report_mismatch("flit", 32'(seen.flit), 32'(flit_o));
                flits_out++;
            end
        end
    end

    // **********************************************************************
    // directed tests
    // **********************************************************************
    task automatic test_reset();
        test_name = "test_reset";
        check_equal("on_off_o", 1, on_off_o);
        check_equal("valid_o", 0, valid_o);
    endtask

    task automatic test_single_flit_routes();
        test_name = "test_single_flit_routes";
        on_off_i  = '1;
        send_packet(4, 2, 1, 1'b0, 0);  // east.
        send_packet(0, 2, 1, 1'b0, 0);  // west.
        send_packet(2, 5, 1, 1'b0, 0);  // north.
        send_packet(2, 1, 1, 1'b0, 0);  // south.
        send_packet(2, 2, 1, 1'b0, 0);  // local.
        wait_drain();
    endtask

    task automatic test_multi_flit_packet();
        test_name = "test_multi_flit_packet";
        on_off_i  = '1;
        send_packet(5, 3, 4, 1'b0, 0);  // east, three followers.
        send_packet(1, 6, 3, 1'b0, 0);  // west, routed on its own.
        wait_drain();
    endtask

    task automatic test_backpressure();
        int out_before;
        test_name = "test_backpressure";
        out_before = flits_out;
        on_off_i = '1;
        on_off_i[noc_pkg::NORTH] = 1'b0;
        send_packet(2, 6, BP_FLITS, 1'b0, 1);  // north, one idle cycle per flit.
        repeat (8) tick();
        check_equal("flits sent while blocked", out_before, flits_out);
        check_equal("valid_o", 0, valid_o);
        check_equal("on_off_o", 0, on_off_o);  // five flits held in the buffer.
        on_off_i = '1;
        wait_drain();
        check_equal("on_off_o after drain", 1, on_off_o);
    endtask

    task automatic test_random_traffic();
        test_name = "test_random_traffic";
        shuffle_outputs();
        for (int p = 0; p < RANDOM_PACKETS; p++)
            send_packet($urandom_range(7), $urandom_range(7), 1 + $urandom_range(3), 1'b1, 0);
        on_off_i = '1;
        wait_drain();
        check_equal("on_off_o after drain", 1, on_off_o);
    endtask

    // **********************************************************************
    // main sequence
    // **********************************************************************
    initial
    begin
        void'($urandom(SEED));
        rst      = 1'b1;
        write_i  = 1'b0;
        flit_i   = '0;
        on_off_i = '1;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        test_reset();
        test_single_flit_routes();
        test_multi_flit_packet();
        test_backpressure();
        test_random_traffic();

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
src/noc_pkg.sv
src/circular_buffer.sv
src/route_compute.sv
src/switch_traversal.sv
src/router_input_port.sv
testbench/tb_router_input_port.sv

//--- Makefile
# Verilator build for the router input port testbench.

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := tb_router_input_port
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only if the log holds the pass line.
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
